// ==== Bender.yml ====
package:
  name: harness

sources:
  - include_dirs:
      - design
    files:
      - design/harness_pkg.sv
      - design/switch_ack_delay.sv
      - design/obi_fifo.sv
      - design/slow_memory.sv
      - design/harness_top.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/harness_tb.sv

// ==== design/harness_config.svh ====
/* Harness configuration
   Latencies, depths and widths of the external slave models */

`ifndef HARNESS_CONFIG_SVH
`define HARNESS_CONFIG_SVH

// Power switch emulation
`define SWITCH_ACK_LATENCY 15
`define NUM_BANKS 4
`define EXT_DOMAINS 2

// Slow memory depth in 32-bit words and its read latency
`define MEM_NUM_WORDS 1024
`define MEM_LATENCY 3

// Request queue in front of the memory
`define OBI_FIFO_DEPTH 2

`endif

// ==== design/harness_pkg.sv ====
/* Harness package
   OBI request and response structs, power domain mask types */

`include "harness_config.svh"

package harness_pkg;

  // One OBI request, driven by the requester
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // One OBI response, driven by the slave
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // One active-low switch bit per bank or domain
  typedef logic [`NUM_BANKS-1:0] bank_mask_t;
  typedef logic [`EXT_DOMAINS-1:0] ext_domain_t;

  // Word index into the slow memory
  typedef logic [$clog2(`MEM_NUM_WORDS)-1:0] word_addr_t;

endpackage

// ==== design/harness_top.sv ====
/* External slave harness
   Slow memory behind an OBI FIFO, plus power switch emulators */

`timescale 1ns/10ps

module harness_top
  import harness_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  obi_req_t    obi_req_i,
  output obi_resp_t   obi_resp_o,
  input  logic        cpu_switch_n_i,
  output logic        cpu_switch_ack_n_o,
  input  logic        periph_switch_n_i,
  output logic        periph_switch_ack_n_o,
  input  bank_mask_t  banks_switch_n_i,
  output bank_mask_t  banks_switch_ack_n_o,
  input  ext_domain_t ext_switch_n_i,
  output ext_domain_t ext_switch_ack_n_o
);

  obi_req_t  mem_req;
  obi_resp_t mem_resp;

  // Extra latency in front of the memory
  obi_fifo u_obi_fifo (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .producer_req_i (obi_req_i),
    .producer_resp_o(obi_resp_o),
    .consumer_req_o (mem_req),
    .consumer_resp_i(mem_resp)
  );

  slow_memory u_slow_memory (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (mem_req),
    .resp_o (mem_resp)
  );

  switch_ack_delay #(.T(logic)) u_cpu_switch (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .switch_n_i(cpu_switch_n_i), .switch_ack_n_o(cpu_switch_ack_n_o)
  );

  switch_ack_delay #(.T(logic)) u_periph_switch (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .switch_n_i(periph_switch_n_i), .switch_ack_n_o(periph_switch_ack_n_o)
  );

  switch_ack_delay #(.T(bank_mask_t)) u_banks_switch (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .switch_n_i(banks_switch_n_i), .switch_ack_n_o(banks_switch_ack_n_o)
  );

  switch_ack_delay #(.T(ext_domain_t)) u_ext_switch (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .switch_n_i(ext_switch_n_i), .switch_ack_n_o(ext_switch_ack_n_o)
  );

endmodule

// ==== design/obi_fifo.sv ====
/* OBI decoupling FIFO
   Queues producer requests and registers consumer responses */

`timescale 1ns/10ps

`include "harness_config.svh"

module obi_fifo
  import harness_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  producer_req_i,
  output obi_resp_t producer_resp_o,
  output obi_req_t  consumer_req_o,
  input  obi_resp_t consumer_resp_i
);

  localparam int unsigned ptr_w = (`OBI_FIFO_DEPTH > 1) ? $clog2(`OBI_FIFO_DEPTH) : 1;
  localparam int unsigned cnt_w = $clog2(`OBI_FIFO_DEPTH + 1);

  obi_req_t         queue_q [`OBI_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  logic             rvalid_q;
  logic [31:0]      rdata_q;
  logic [7:0]       outstanding_q;

  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(`OBI_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count_q == cnt_w'(`OBI_FIFO_DEPTH));
  assign empty = (count_q == '0);
  assign push  = producer_req_i.req & ~full;
  assign pop   = ~empty & consumer_resp_i.gnt;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) queue_q[wr_ptr_q] <= producer_req_i;
  end

  // Head of the queue goes downstream
  always_comb begin
    consumer_req_o     = queue_q[rd_ptr_q];
    consumer_req_o.req = ~empty;
  end

  // Response stage
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= consumer_resp_i.rvalid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (consumer_resp_i.rvalid) rdata_q <= consumer_resp_i.rdata;
  end

  assign producer_resp_o.gnt    = ~full;
  assign producer_resp_o.rvalid = rvalid_q;
  assign producer_resp_o.rdata  = rdata_q;

  // Accepted but not yet answered
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= '0;
    end else begin
      case ({push, rvalid_q})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  // A full queue has its write pointer back on the head entry
  full_ptr_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    full |-> wr_ptr_q == rd_ptr_q
  ) else $error("full queue with write pointer off the head entry");

  resp_outstanding_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    consumer_resp_i.rvalid |-> outstanding_q != '0
  ) else $error("response without an outstanding request");

endmodule

// ==== design/slow_memory.sv ====
/* Slow external memory
   Byte-enabled word storage behind a fixed-latency read pipeline */

`timescale 1ns/10ps

`include "harness_config.svh"

module slow_memory
  import harness_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  logic [31:0]             mem_q [`MEM_NUM_WORDS];
  word_addr_t              word_idx;
  logic [`MEM_LATENCY-1:0] valid_q;
  logic [31:0]             data_q [`MEM_LATENCY];

  // Upper address bits dropped, so the memory aliases
  assign word_idx = req_i.addr[$bits(word_addr_t)+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data sampled at acceptance, before this cycle's write lands
  always_ff @(posedge clk_i) begin
    data_q[0] <= mem_q[word_idx];
    for (int i = 1; i < `MEM_LATENCY; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= req_i.req;
      for (int i = 1; i < `MEM_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Every request is taken at once
  assign resp_o.gnt    = 1'b1;
  assign resp_o.rvalid = valid_q[`MEM_LATENCY-1];
  assign resp_o.rdata  = data_q[`MEM_LATENCY-1];

  fixed_latency_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    resp_o.rvalid == $past(req_i.req, `MEM_LATENCY)
  ) else $error("memory response off its fixed latency");

endmodule

// ==== design/switch_ack_delay.sv ====
/* Power switch acknowledge emulation
   Returns the switch command after a fixed settling delay */

`timescale 1ns/10ps

`include "harness_config.svh"

module switch_ack_delay #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  T     switch_n_i,
  output T     switch_ack_n_o
);

  T stage_q [`SWITCH_ACK_LATENCY];

  // Stands in for the analog settling time of the switch cell
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < `SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[`SWITCH_ACK_LATENCY-1];

  // Driven acknowledge once out of reset
  ack_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(switch_ack_n_o)
  ) else $error("switch acknowledge holds X");

endmodule

// ==== tb.f ====
+incdir+design
+incdir+tests
design/harness_pkg.sv
design/switch_ack_delay.sv
design/obi_fifo.sv
design/slow_memory.sv
design/harness_top.sv
tests/harness_tb.sv

// ==== tests/harness_tb_ref.svh ====
/* Testbench reference model
   Random source, memory model and value check */

`ifndef HARNESS_TB_REF_SVH
`define HARNESS_TB_REF_SVH

logic [31:0] lfsr_state = 32'h4ecd_4873;
logic [31:0] model_mem [`MEM_NUM_WORDS];

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] nxt;
  nxt = s >> 1;
  if (s[0]) nxt = nxt ^ 32'h8020_0003;
  return nxt;
endfunction

function logic [31:0] random_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

// Sixteen spread-out words written before any read
function automatic logic [31:0] pool_addr(input logic [31:0] k);
  return (k * 65) << 2;
endfunction

function automatic int word_index(input logic [31:0] addr);
  return (addr >> 2) % `MEM_NUM_WORDS;
endfunction

function void store_word(input logic [31:0] addr, input logic [3:0] be,
                         input logic [31:0] wdata);
  logic [31:0] mask;
  mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  model_mem[word_index(addr)] = (model_mem[word_index(addr)] & ~mask) | (wdata & mask);
endfunction

function logic [31:0] expected_word(input logic [31:0] addr);
  return model_mem[word_index(addr)];
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    $display("[FAIL] %0t %s got %h expected %h", $time, name, actual, expected);
    $display("Test failed");
    $fatal(1);
  end
endtask

`endif

// ==== tests/harness_tb.sv ====
/* Harness testbench
   Drives the OBI memory path and the power switch lines, checks responses */

`timescale 1ns/10ps

`include "harness_config.svh"

module harness_tb
  import harness_pkg::*;
();

  localparam int NUM_OPS = 16 * 4 + 200;
  localparam int WATCHDOG_CYCLES =
    NUM_OPS * (`MEM_LATENCY + 8) + `SWITCH_ACK_LATENCY * 40 + 200;
  localparam int SW_W = 2 + `NUM_BANKS + `EXT_DOMAINS;

  typedef struct packed {
    logic        is_read;
    logic [31:0] data;
  } exp_t;

  logic        clk_i;
  logic        rst_n_i;
  obi_req_t    obi_req;
  obi_resp_t   obi_resp_o;
  logic        cpu_sw;
  logic        cpu_ack;
  logic        periph_sw;
  logic        periph_ack;
  bank_mask_t  banks_sw;
  bank_mask_t  banks_ack;
  ext_domain_t ext_sw;
  ext_domain_t ext_ack;
  exp_t        expected_q [$];

  `include "harness_tb_ref.svh"

  harness_top UUT (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .obi_req_i            (obi_req),
    .obi_resp_o           (obi_resp_o),
    .cpu_switch_n_i       (cpu_sw),
    .cpu_switch_ack_n_o   (cpu_ack),
    .periph_switch_n_i    (periph_sw),
    .periph_switch_ack_n_o(periph_ack),
    .banks_switch_n_i     (banks_sw),
    .banks_switch_ack_n_o (banks_ack),
    .ext_switch_n_i       (ext_sw),
    .ext_switch_ack_n_o   (ext_ack)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Called on a falling edge, returns on the falling edge after the grant
  task automatic obi_access(input logic we, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata);
    exp_t entry;
    logic granted;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    granted = 1'b0;
    while (!granted) begin
      @(posedge clk_i);
      granted = obi_resp_o.gnt;
      @(negedge clk_i);
    end
    entry.is_read = !we;
    entry.data    = '0;
    if (we) begin
      store_word(addr, be, wdata);
    end else begin
      entry.data = expected_word(addr);
    end
    expected_q.push_back(entry);
  endtask

  task automatic switch_sweep(input int cycles);
    logic [SW_W-1:0] cmd;
    logic [SW_W-1:0] exp_cmd;
    logic [SW_W-1:0] hist [$];
    for (int c = 0; c < cycles; c++) begin
      cmd = random_bits(SW_W);
      {cpu_sw, periph_sw, banks_sw, ext_sw} = cmd;
      hist.push_back(cmd);
      @(posedge clk_i);
      if (hist.size() > `SWITCH_ACK_LATENCY) begin
        exp_cmd = hist[hist.size() - 1 - `SWITCH_ACK_LATENCY];
        check_value("cpu_switch_ack_n_o", cpu_ack, exp_cmd[SW_W-1]);
        check_value("periph_switch_ack_n_o", periph_ack, exp_cmd[SW_W-2]);
        check_value("banks_switch_ack_n_o", banks_ack,
                    exp_cmd[`EXT_DOMAINS +: `NUM_BANKS]);
        check_value("ext_switch_ack_n_o", ext_ack, exp_cmd[`EXT_DOMAINS-1:0]);
      end
      @(negedge clk_i);
    end
  endtask

  // One expected entry popped per rvalid
  initial begin
    exp_t exp_entry;
    @(posedge rst_n_i);
    forever begin
      @(posedge clk_i);
      if (obi_resp_o.rvalid) begin
        if (expected_q.size() == 0) begin
          $display("rvalid seen at %0t with no request outstanding", $time);
          $display("Test failed");
          $fatal(1);
        end else begin
          exp_entry = expected_q.pop_front();
          if (exp_entry.is_read) begin
            check_value("obi_resp_o.rdata", obi_resp_o.rdata, exp_entry.data);
          end
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    int drain;
    rst_n_i   = 1'b0;
    obi_req   = '0;
    cpu_sw    = 1'b1;
    periph_sw = 1'b1;
    banks_sw  = '1;
    ext_sw    = '1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      check_value("cpu_switch_ack_n_o", cpu_ack, 1'b1);
      check_value("periph_switch_ack_n_o", periph_ack, 1'b1);
      check_value("banks_switch_ack_n_o", banks_ack, {`NUM_BANKS{1'b1}});
      check_value("ext_switch_ack_n_o", ext_ack, {`EXT_DOMAINS{1'b1}});
      check_value("obi_resp_o.rvalid", obi_resp_o.rvalid, 1'b0);
      check_value("obi_resp_o.gnt", obi_resp_o.gnt, 1'b1);
    end
    @(negedge clk_i);
    switch_sweep(60);

    // Full-word writes followed by reads
    for (int k = 0; k < 16; k++) obi_access(1'b1, 4'hf, pool_addr(k), random_bits(32));
    for (int k = 0; k < 16; k++) obi_access(1'b0, 4'h0, pool_addr(k), 32'h0);
    // Byte-enable merges
    for (int k = 0; k < 16; k++) obi_access(1'b1, random_bits(4), pool_addr(k), random_bits(32));
    for (int k = 0; k < 16; k++) obi_access(1'b0, 4'h0, pool_addr(k), 32'h0);
    // Mixed traffic including aliased addresses
    for (int n = 0; n < 200; n++) begin
      obi_access(random_bits(1), random_bits(4),
                 pool_addr(random_bits(4)) | (random_bits(3) << 12), random_bits(32));
    end
    obi_req.req = 1'b0;

    drain = 0;
    while (expected_q.size() != 0 && drain < 50) begin
      @(posedge clk_i);
      drain++;
    end
    if (expected_q.size() != 0) begin
      $display("%0d responses never arrived", expected_q.size());
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule
